//--- build.f
design/workgroup_pkg.sv
design/shared_ram.sv
design/mem_arbiter.sv
design/dbg_apb_port.sv
design/workgroup.sv
dv/tb_clkgen.sv
dv/wg_checker.sv
dv/tb_workgroup.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_workgroup
OBJ_DIR ?= obj_dir
FILELIST ?= build.f
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_workgroup.sv
`timescale 1ns/1ps

module tb_workgroup;

import workgroup_pkg::*;

localparam int CPU_NUM = 3;
localparam int MEM_WORDS = 256;
localparam int TMO = 50;                                    // Cycles per wait

typedef enum {OP_CWR, OP_CRD, OP_DWR, OP_DRD, OP_REGRD, OP_CONT, OP_PROT} op_e;

typedef struct {
    string name;
    op_e op;
    int port;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] exp_data;
    logic exp_err;
} step_t;

logic clk, rst_n;
mem_req_t core_req [CPU_NUM];
mem_resp_t core_resp [CPU_NUM];
apb_req_t apb_req;
apb_resp_t apb_resp;
int errors;
int timeouts = 0;
step_t steps[$];
logic [DATA_W-1:0] d [5];
logic [DATA_W-1:0] cdat [CPU_NUM+1];

tb_clkgen #(.PERIOD(40), .RST_CYCLES(8)) clkgen (.o_clk(clk), .o_rst_n(rst_n));

workgroup #(.CPU_NUM(CPU_NUM), .MEM_WORDS(MEM_WORDS)) workgroup_inst (
    .i_clk(clk),
    .i_rst_n(rst_n),
    .i_core_req(core_req),
    .o_core_resp(core_resp),
    .i_apb_req(apb_req),
    .o_apb_resp(apb_resp)
);

wg_checker #(.CPU_NUM(CPU_NUM), .MEM_WORDS(MEM_WORDS)) chk (
    .i_clk(clk),
    .i_rst_n(rst_n),
    .i_core_req(core_req),
    .i_core_resp(core_resp),
    .i_apb_req(apb_req),
    .i_apb_resp(apb_resp),
    .o_errors(errors)
);

task automatic add(string name, op_e op, int port, logic [ADDR_W-1:0] addr,
                   logic [DATA_W-1:0] data, logic [DATA_W-1:0] exp_data, logic exp_err);
    steps.push_back('{name, op, port, addr, data, exp_data, exp_err});
endtask

task automatic core_access(int p, logic we, logic [ADDR_W-1:0] a, logic [DATA_W-1:0] wd);
    int n = 0;
    @(negedge clk);
    core_req[p] = '{valid: 1'b1, we: we, addr: a, wdata: wd};
    do begin
        @(negedge clk);
        n++;
    end while (!core_resp[p].valid && n < TMO);
    if (!core_resp[p].valid) begin
        timeouts++;
        $display("timeout: core %0d got no response for address %h", p, a);
    end
    @(negedge clk);
    core_req[p].valid = 1'b0;                               // Cycle after the response
endtask

task automatic apb_xfer(logic wr, logic [7:0] a, logic [DATA_W-1:0] wd,
                        output logic [DATA_W-1:0] rd);
    @(negedge clk);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: a, pwdata: wd};
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(posedge clk);
    rd = apb_resp.prdata;
    @(negedge clk);
    apb_req = '0;
endtask

task automatic dbg_start(logic we, logic [ADDR_W-1:0] a, logic [DATA_W-1:0] wd);
    logic [DATA_W-1:0] rd;
    apb_xfer(1'b1, DBG_ADDR, 32'(a), rd);
    apb_xfer(1'b1, DBG_WDATA, wd, rd);
    apb_xfer(1'b1, DBG_CMD, 32'(we), rd);
endtask

task automatic dbg_finish(logic we);
    logic [DATA_W-1:0] rd;
    int n = 0;
    do begin
        apb_xfer(1'b0, DBG_STATUS, '0, rd);
        n++;
    end while (rd[0] && n < TMO);
    if (rd[0]) begin
        timeouts++;
        $display("timeout: debug port stayed busy");
    end
    if (!we) apb_xfer(1'b0, DBG_RDATA, '0, rd);
endtask

task automatic run_contention(logic [ADDR_W-1:0] base);
    logic [DATA_W-1:0] rd;
    // Debug address and data first, so the CMD write lands with the core requests
    apb_xfer(1'b1, DBG_ADDR, 32'(ADDR_W'(base + CPU_NUM)), rd);
    apb_xfer(1'b1, DBG_WDATA, cdat[CPU_NUM], rd);
    for (int p = 0; p < CPU_NUM; p++) begin
        automatic int q = p;
        fork
            core_access(q, 1'b1, ADDR_W'(base + q), cdat[q]);
        join_none
    end
    apb_xfer(1'b1, DBG_CMD, 32'd1, rd);
    dbg_finish(1'b1);
    wait fork;
endtask

task automatic protocol_errors(logic [ADDR_W-1:0] a, logic [DATA_W-1:0] wd);
    logic [DATA_W-1:0] rd;
    dbg_start(1'b1, a, wd);
    apb_xfer(1'b1, DBG_CMD, '0, rd);                        // Rejected while busy
    apb_xfer(1'b0, 8'h14, '0, rd);                          // Undefined offset
    dbg_finish(1'b1);
endtask

initial begin
    step_t s;
    int n;
    core_req = '{default: '0};
    apb_req = '0;
    void'($urandom(32'hb1cf_a324));
    foreach (d[i]) d[i] = $urandom;
    foreach (cdat[i]) cdat[i] = $urandom;

    add("reset_state", OP_REGRD, 0, '0, '0, '0, 1'b0);
    add("shared_wr", OP_CWR, 0, 16'h0010, d[0], '0, 1'b0);
    add("shared_rd1", OP_CRD, 1, 16'h0010, '0, d[0], 1'b0);
    add("shared_rd2", OP_CRD, 2, 16'h0010, '0, d[0], 1'b0);
    add("dbg_wr", OP_DWR, 0, 16'h0020, d[1], '0, 1'b0);
    add("dbg_wr_seen", OP_CRD, 2, 16'h0020, '0, d[1], 1'b0);
    add("core_wr", OP_CWR, 1, 16'h0021, d[2], '0, 1'b0);
    add("dbg_rd", OP_DRD, 0, 16'h0021, '0, d[2], 1'b0);
    add("core_oor_wr", OP_CWR, 0, 16'h0100, d[3], '0, 1'b1);
    add("core_oor_rd", OP_CRD, 1, 16'h0100, '0, '0, 1'b1);
    add("dbg_oor_wr", OP_DWR, 0, 16'h1234, d[3], '0, 1'b1);
    add("dbg_oor_rd", OP_DRD, 0, 16'h0200, '0, '0, 1'b1);
    add("oor_alias0", OP_CRD, 0, 16'h0000, '0, '0, 1'b0);
    add("oor_alias34", OP_CRD, 2, 16'h0034, '0, '0, 1'b0);
    add("contention", OP_CONT, 0, 16'h0040, '0, '0, 1'b0);
    for (int i = 0; i <= CPU_NUM; i++) begin
        add($sformatf("cont_rd%0d", i), OP_CRD, i % CPU_NUM, ADDR_W'(16'h0040 + i), '0,
            cdat[i], 1'b0);
    end
    add("prot_busy", OP_PROT, 0, 16'h0050, d[4], '0, 1'b0);
    add("prot_rd", OP_CRD, 0, 16'h0050, '0, d[4], 1'b0);

    n = 0;
    while (rst_n !== 1'b1 && n < TMO) begin
        @(posedge clk);
        n++;
    end
    if (rst_n !== 1'b1) begin
        timeouts++;
        $display("timeout: reset was never released");
    end
    foreach (steps[i]) begin
        s = steps[i];
        chk.set_test(s.name, s.op == OP_CRD || s.op == OP_DRD || s.op == OP_REGRD,
            s.exp_data, s.exp_err);
        case (s.op)
            OP_CWR: core_access(s.port, 1'b1, s.addr, s.data);
            OP_CRD: core_access(s.port, 1'b0, s.addr, '0);
            OP_DWR, OP_DRD: begin
                dbg_start(s.op == OP_DWR, s.addr, s.data);
                dbg_finish(s.op == OP_DWR);
            end
            OP_REGRD: begin
                dbg_finish(1'b0);                           // Status then read data
            end
            OP_CONT: run_contention(s.addr);
            OP_PROT: protocol_errors(s.addr, s.data);
            default: $display("unknown table operation in %s", s.name);
        endcase
    end

    repeat (2) @(negedge clk);
    $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
        $display("TESTS PASSED");
    end else begin
        $display("TESTS FAILED");
    end
    $finish;
end

endmodule: tb_workgroup

//--- dv/wg_checker.sv
`timescale 1ns/1ps

module wg_checker #(
    parameter int unsigned CPU_NUM = 3,
    parameter int unsigned MEM_WORDS = 256
)
(
    input logic i_clk,
    input logic i_rst_n,
    input workgroup_pkg::mem_req_t i_core_req [CPU_NUM],
    input workgroup_pkg::mem_resp_t i_core_resp [CPU_NUM],
    input workgroup_pkg::apb_req_t i_apb_req,
    input workgroup_pkg::apb_resp_t i_apb_resp,
    output int o_errors
);

import workgroup_pkg::*;

localparam int unsigned IDX_W = $clog2(MEM_WORDS);

logic [DATA_W-1:0] ref_mem [MEM_WORDS];
logic [ADDR_W-1:0] s_addr, p_addr;                          // Debug registers and pending access
logic [DATA_W-1:0] s_wdata, s_rdata, p_wdata, t_data;
logic s_err, pend, p_we, t_chk, t_err;
string t_name = "none";
int errors = 0;

assign o_errors = errors;

task set_test(string name, logic chk, logic [DATA_W-1:0] exp_data, logic exp_err);
    t_name = name;
    t_chk = chk;
    t_data = exp_data;
    t_err = exp_err;
endtask

task automatic compare(string what, logic [DATA_W:0] exp, logic [DATA_W:0] act);
    if (exp !== act) begin
        errors++;
        $display("mismatch %s %s: expected %h actual %h", t_name, what, exp, act);
    end
endtask

task automatic check_core(int p);
    mem_req_t q;
    logic bad;
    logic [DATA_W-1:0] exp_d;
    q = i_core_req[p];
    if (!q.valid) begin
        errors++;
        $display("core %0d gave a response with no request pending in %s", p, t_name);
        return;
    end
    bad = 32'(q.addr) >= MEM_WORDS;
    exp_d = (bad || q.we) ? '0 : ref_mem[q.addr[IDX_W-1:0]];
    compare($sformatf("core%0d", p), {bad, exp_d}, {i_core_resp[p].err, i_core_resp[p].rdata});
    if (t_chk && !q.we) begin
        compare("table", {t_err, t_data}, {i_core_resp[p].err, i_core_resp[p].rdata});
    end
    if (!bad && q.we) ref_mem[q.addr[IDX_W-1:0]] = q.wdata;
endtask

task automatic check_apb();
    apb_req_t r;
    logic known;
    logic bad;
    logic [DATA_W-1:0] exp_rd;
    r = i_apb_req;
    known = r.paddr inside {DBG_ADDR, DBG_WDATA, DBG_CMD, DBG_STATUS, DBG_RDATA};
    // Zero wait states on every transfer
    compare("pready", {32'b0, 1'b1}, {32'b0, i_apb_resp.pready});
    compare("pslverr", {32'b0, !known || (r.pwrite && r.paddr == DBG_CMD && pend)},
        {32'b0, i_apb_resp.pslverr});
    if (r.pwrite) begin
        if (r.paddr == DBG_ADDR) s_addr = r.pwdata[ADDR_W-1:0];
        if (r.paddr == DBG_WDATA) s_wdata = r.pwdata;
        if (r.paddr == DBG_CMD && !pend) begin
            pend = 1'b1;
            p_we = r.pwdata[0];
            p_addr = s_addr;
            p_wdata = s_wdata;
        end
    end else begin
        // Busy seen clear, so the pending access has hit the RAM
        if (r.paddr == DBG_STATUS && pend && !i_apb_resp.prdata[0]) begin
            bad = 32'(p_addr) >= MEM_WORDS;
            s_err = bad;
            pend = 1'b0;
            if (!bad && p_we) ref_mem[p_addr[IDX_W-1:0]] = p_wdata;
            if (!p_we) s_rdata = bad ? '0 : ref_mem[p_addr[IDX_W-1:0]];
        end
        exp_rd = '0;
        case (r.paddr)
            DBG_ADDR: exp_rd = 32'(s_addr);
            DBG_WDATA: exp_rd = s_wdata;
            DBG_CMD: exp_rd = 32'(p_we);
            DBG_STATUS: exp_rd = {30'b0, s_err, pend};
            DBG_RDATA: exp_rd = s_rdata;
            default: exp_rd = '0;
        endcase
        compare("prdata", {1'b0, exp_rd}, {1'b0, i_apb_resp.prdata});
        if (r.paddr == DBG_RDATA && t_chk) begin
            compare("table", {1'b0, t_data}, {1'b0, i_apb_resp.prdata});
        end
    end
endtask

always @(posedge i_clk) begin
    if (!i_rst_n) begin
        for (int i = 0; i < int'(MEM_WORDS); i++) ref_mem[i] = '0;
        {s_addr, p_addr, s_wdata, s_rdata, p_wdata} = '0;
        {s_err, pend, p_we} = '0;
    end else begin
        for (int p = 0; p < int'(CPU_NUM); p++) begin
            if (i_core_resp[p].valid) check_core(p);
        end
        if (i_apb_req.psel && i_apb_req.penable) check_apb();
    end
end

endmodule: wg_checker

//--- dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD = 40,
    parameter int RST_CYCLES = 8
)
(
    output logic o_clk,
    output logic o_rst_n
);

initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
end

initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;                                         // Release away from the active edge
end

endmodule: tb_clkgen

//--- design/workgroup.sv
`timescale 1ns/1ps

module workgroup #(
    parameter int unsigned CPU_NUM = 3,
    parameter int unsigned MEM_WORDS = 256                  // At most 2**ADDR_W
)
(
    input logic i_clk,
    input logic i_rst_n,
    input workgroup_pkg::mem_req_t i_core_req [CPU_NUM],
    output workgroup_pkg::mem_resp_t o_core_resp [CPU_NUM],
    input workgroup_pkg::apb_req_t i_apb_req,               // Debug access
    output workgroup_pkg::apb_resp_t o_apb_resp
);

import workgroup_pkg::*;

mem_req_t w_mst_req [CPU_NUM+1];
mem_resp_t w_mst_resp [CPU_NUM+1];
mem_req_t w_ram_req;
mem_resp_t w_ram_resp;

// Core ports take the low arbiter slots
generate
    for (genvar i = 0; i < CPU_NUM; i++) begin: xslotcore
        assign w_mst_req[i] = i_core_req[i];
        assign o_core_resp[i] = w_mst_resp[i];
    end: xslotcore
endgenerate

dbg_apb_port dbg0 (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_apb_req(i_apb_req),
    .o_apb_resp(o_apb_resp),
    .o_mem_req(w_mst_req[CPU_NUM]),                         // Last slot
    .i_mem_resp(w_mst_resp[CPU_NUM])
);

mem_arbiter #(
    .CPU_NUM(CPU_NUM)
) arb0 (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_mst_req(w_mst_req),
    .o_mst_resp(w_mst_resp),
    .o_ram_req(w_ram_req),
    .i_ram_resp(w_ram_resp)
);

shared_ram #(
    .MEM_WORDS(MEM_WORDS)
) ram0 (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_req(w_ram_req),
    .o_resp(w_ram_resp)
);

endmodule: workgroup

//--- design/dbg_apb_port.sv
`timescale 1ns/1ps

module dbg_apb_port (
    input logic i_clk,
    input logic i_rst_n,
    input workgroup_pkg::apb_req_t i_apb_req,
    output workgroup_pkg::apb_resp_t o_apb_resp,
    output workgroup_pkg::mem_req_t o_mem_req,              // Arbiter slot CPU_NUM
    input workgroup_pkg::mem_resp_t i_mem_resp
);

import workgroup_pkg::*;

logic [ADDR_W-1:0] r_addr;
logic [DATA_W-1:0] r_wdata;
logic [DATA_W-1:0] r_rdata;
logic r_err;
mem_req_t r_req;                                            // valid doubles as busy
logic w_access;
logic w_wr;
logic w_known;
logic w_cmd_wr;
logic w_cmd_go;
logic [DATA_W-1:0] w_rdata;

assign w_access = i_apb_req.psel && i_apb_req.penable;
assign w_wr = w_access && i_apb_req.pwrite;
assign w_cmd_wr = w_wr && (i_apb_req.paddr == DBG_CMD);
assign w_cmd_go = w_cmd_wr && !r_req.valid;

// Register read mux
always_comb begin
    w_known = 1'b1;
    w_rdata = '0;
    case (i_apb_req.paddr)
        DBG_ADDR: w_rdata = DATA_W'(r_addr);
        DBG_WDATA: w_rdata = r_wdata;
        DBG_CMD: w_rdata = DATA_W'(r_req.we);
        DBG_STATUS: w_rdata = DATA_W'({r_err, r_req.valid});
        DBG_RDATA: w_rdata = r_rdata;
        default: w_known = 1'b0;                            // Reads as zero
    endcase
end

// Zero wait states
always_comb begin
    o_apb_resp.pready = 1'b1;
    o_apb_resp.pslverr = w_access && (!w_known || (w_cmd_wr && r_req.valid));
    o_apb_resp.prdata = w_rdata;
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        r_addr <= '0;
        r_wdata <= '0;
        r_rdata <= '0;
        r_err <= 1'b0;
        r_req <= '0;
    end else begin
        if (w_wr && i_apb_req.paddr == DBG_ADDR) begin
            r_addr <= i_apb_req.pwdata[ADDR_W-1:0];
        end
        if (w_wr && i_apb_req.paddr == DBG_WDATA) begin
            r_wdata <= i_apb_req.pwdata;
        end

        if (w_cmd_go) begin
            // Snapshot so later register writes leave the request alone
            r_req.valid <= 1'b1;
            r_req.we <= i_apb_req.pwdata[0];
            r_req.addr <= r_addr;
            r_req.wdata <= r_wdata;
        end else if (r_req.valid && i_mem_resp.valid) begin
            r_req.valid <= 1'b0;
            r_err <= i_mem_resp.err;
            if (!r_req.we) begin
                r_rdata <= i_mem_resp.rdata;
            end
        end
    end
end

assign o_mem_req = r_req;

a_req_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_mem_req.valid && !i_mem_resp.valid |=> $stable(o_mem_req))
    else $error("debug request changed while waiting");

a_resp_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_mem_resp.valid |-> o_mem_req.valid)
    else $error("debug response without a pending access");

endmodule: dbg_apb_port

//--- design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int unsigned CPU_NUM = 3
)
(
    input logic i_clk,
    input logic i_rst_n,
    input workgroup_pkg::mem_req_t i_mst_req [CPU_NUM+1],   // Cores first, debug last
    output workgroup_pkg::mem_resp_t o_mst_resp [CPU_NUM+1],
    output workgroup_pkg::mem_req_t o_ram_req,
    input workgroup_pkg::mem_resp_t i_ram_resp
);

import workgroup_pkg::*;

localparam int unsigned NMST = CPU_NUM + 1;
localparam int unsigned IDX_W = $clog2(NMST);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,                                               // Request on the RAM port
    ST_WAIT                                                 // RAM answers here
} state_e;

state_e r_state;
logic [IDX_W-1:0] r_owner;                                  // Also the last grant
mem_req_t r_req;
logic w_gnt_valid;
logic [IDX_W-1:0] w_gnt_idx;
logic [NMST-1:0] w_resp_valid;

// Search starts at the slot after the last grant and wraps
always_comb begin : rr_pick
    int idx;
    w_gnt_valid = 1'b0;
    w_gnt_idx = r_owner;
    for (int k = 1; k <= int'(NMST); k++) begin
        idx = (int'(r_owner) + k) % int'(NMST);
        if (!w_gnt_valid && i_mst_req[idx].valid) begin
            w_gnt_valid = 1'b1;
            w_gnt_idx = IDX_W'(idx);
        end
    end
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        r_state <= ST_IDLE;
        r_owner <= IDX_W'(CPU_NUM);                         // Debug slot, so core 0 wins first
    end else begin
        case (r_state)
            ST_IDLE: begin
                if (w_gnt_valid) begin
                    r_owner <= w_gnt_idx;
                    r_state <= ST_ISSUE;
                end
            end
            ST_ISSUE: r_state <= ST_WAIT;
            ST_WAIT: begin
                if (i_ram_resp.valid) begin
                    r_state <= ST_IDLE;
                end
            end
            default: r_state <= ST_IDLE;
        endcase
    end
end

always_ff @(posedge i_clk) begin
    if (r_state == ST_IDLE && w_gnt_valid) begin
        r_req <= i_mst_req[w_gnt_idx];
    end
end

always_comb begin
    o_ram_req = r_req;
    o_ram_req.valid = (r_state == ST_ISSUE);                // One-cycle pulse
end

// Steer the RAM answer to the owner only
always_comb begin
    for (int i = 0; i < int'(NMST); i++) begin
        o_mst_resp[i] = '0;
        if (r_state == ST_WAIT && r_owner == IDX_W'(i)) begin
            o_mst_resp[i] = i_ram_resp;
        end
        w_resp_valid[i] = o_mst_resp[i].valid;
    end
end

a_one_resp: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(w_resp_valid))
    else $error("more than one master response valid");

a_resp_in_wait: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_ram_resp.valid |-> r_state == ST_WAIT)
    else $error("RAM response outside the wait state");

endmodule: mem_arbiter

//--- design/shared_ram.sv
`timescale 1ns/1ps

module shared_ram #(
    parameter int unsigned MEM_WORDS = 256
)
(
    input logic i_clk,
    input logic i_rst_n,
    input workgroup_pkg::mem_req_t i_req,                   // Single-cycle request from arbiter
    output workgroup_pkg::mem_resp_t o_resp                 // Answer one cycle later
);

import workgroup_pkg::*;

localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

logic [DATA_W-1:0] mem [MEM_WORDS];
logic [IDX_W-1:0] w_idx;
logic w_in_range;
mem_resp_t r_resp;

assign w_idx = i_req.addr[IDX_W-1:0];
// One extra bit so a full 2**ADDR_W deep RAM still compares correctly
assign w_in_range = ({1'b0, i_req.addr} < (ADDR_W+1)'(MEM_WORDS));

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= '0;
        end
    end else if (i_req.valid && i_req.we && w_in_range) begin
        mem[w_idx] <= i_req.wdata;
    end
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        r_resp <= '0;
    end else begin
        r_resp.valid <= i_req.valid;
        r_resp.err <= i_req.valid && !w_in_range;
        if (i_req.valid) begin
            // Writes and bad addresses answer with zero data
            r_resp.rdata <= (!i_req.we && w_in_range) ? mem[w_idx] : '0;
        end
    end
end

assign o_resp = r_resp;

endmodule: shared_ram

//--- design/workgroup_pkg.sv
package workgroup_pkg;

    // Datapath sizes
    localparam int DATA_W = 32;
    localparam int ADDR_W = 16;              // Word address
    localparam int APB_AW = 8;               // Debug register byte offset

    // Memory request from a core or the debug port
    typedef struct packed {
        logic valid;
        logic we;                            // 1 = write
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    // Memory response, a one-cycle pulse
    typedef struct packed {
        logic valid;
        logic err;                           // Address out of range
        logic [DATA_W-1:0] rdata;
    } mem_resp_t;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [APB_AW-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic pready;
        logic pslverr;
        logic [DATA_W-1:0] prdata;
    } apb_resp_t;

    // Debug register map
    localparam logic [APB_AW-1:0] DBG_ADDR = 8'h00;
    localparam logic [APB_AW-1:0] DBG_WDATA = 8'h04;
    localparam logic [APB_AW-1:0] DBG_CMD = 8'h08;      // Bit 0 selects write
    localparam logic [APB_AW-1:0] DBG_STATUS = 8'h0C;   // Bit 0 busy, bit 1 error
    localparam logic [APB_AW-1:0] DBG_RDATA = 8'h10;

endpackage: workgroup_pkg
